// ==== rtl/mipsPkg.sv ====
package mipsPkg;

    // datapath widths.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opCode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [1:0]  aluOp_t;

    // opcode field, bits 31:26.
    localparam opCode_t opRType = 6'b000000;
    localparam opCode_t opLw    = 6'b100011;
    localparam opCode_t opSw    = 6'b101011;
    localparam opCode_t opBeq   = 6'b000100;
    localparam opCode_t opAddi  = 6'b001000;
    localparam opCode_t opJ     = 6'b000010;

    // funct field of R-type, bits 5:0.
    localparam funct_t fnAdd = 6'b100000;
    localparam funct_t fnSub = 6'b100010;
    localparam funct_t fnAnd = 6'b100100;
    localparam funct_t fnOr  = 6'b100101;
    localparam funct_t fnSlt = 6'b101010;

    // operation class handed from decoder to ALU.
    localparam aluOp_t aluAdd   = 2'b00; // address or immediate.
    localparam aluOp_t aluSub   = 2'b01; // beq compare.
    localparam aluOp_t aluFunct = 2'b10;

endpackage

// ==== rtl/ControlUnit.sv ====
`timescale 1ns/1ps

module ControlUnit (
    input  mipsPkg::opCode_t opCode,
    output logic             regDst,
    output logic             jump,
    output logic             branch,
    output logic             memRead,
    output logic             memToReg,
    output mipsPkg::aluOp_t  aluOp,
    output logic             memWrite,
    output logic             aluSource,
    output logic             regWrite
);

    import mipsPkg::*;

    always_comb begin
        case (opCode)
            opRType: begin
                regDst    = 1'b1; // write to rd.
                aluSource = 1'b0;
                memToReg  = 1'b0;
                regWrite  = 1'b1;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                branch    = 1'b0;
                aluOp     = aluFunct;
                jump      = 1'b0;
            end
            opLw: begin
                regDst    = 1'b0;
                aluSource = 1'b1; // base plus offset.
                memToReg  = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
                memWrite  = 1'b0;
                branch    = 1'b0;
                aluOp     = aluAdd;
                jump      = 1'b0;
            end
            opSw: begin
                regDst    = 1'b0;
                aluSource = 1'b1;
                memToReg  = 1'b0;
                regWrite  = 1'b0;
                memRead   = 1'b0;
                memWrite  = 1'b1;
                branch    = 1'b0;
                aluOp     = aluAdd;
                jump      = 1'b0;
            end
            opBeq: begin
                regDst    = 1'b0;
                aluSource = 1'b0;
                memToReg  = 1'b0;
                regWrite  = 1'b0;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                branch    = 1'b1;
                aluOp     = aluSub; // zero flag means equal.
                jump      = 1'b0;
            end
            opAddi: begin
                regDst    = 1'b0;
                aluSource = 1'b1;
                memToReg  = 1'b0;
                regWrite  = 1'b1;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                branch    = 1'b0;
                aluOp     = aluAdd;
                jump      = 1'b0;
            end
            opJ: begin
                regDst    = 1'b0;
                aluSource = 1'b0;
                memToReg  = 1'b0;
                regWrite  = 1'b0;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                branch    = 1'b0;
                aluOp     = aluAdd;
                jump      = 1'b1;
            end
            default: begin
                // unsupported opcode runs as a no-op.
                regDst    = 1'b0;
                aluSource = 1'b0;
                memToReg  = 1'b0;
                regWrite  = 1'b0;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                branch    = 1'b0;
                aluOp     = aluAdd;
                jump      = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/Alu.sv ====
`timescale 1ns/1ps

module Alu (
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  mipsPkg::aluOp_t aluOp,
    input  mipsPkg::funct_t funct,
    output mipsPkg::word_t  result,
    output logic            zero
);

    import mipsPkg::*;

    word_t sum;
    word_t diff;
    logic  lessThan;

    assign sum      = a + b;
    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b); // slt is signed.

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = sum;
            end
            aluSub: begin
                result = diff;
            end
            aluFunct: begin
                case (funct)
                    fnAdd: begin
                        result = sum;
                    end
                    fnSub: begin
                        result = diff;
                    end
                    fnAnd: begin
                        result = a & b;
                    end
                    fnOr: begin
                        result = a | b;
                    end
                    fnSlt: begin
                        result = {31'd0, lessThan};
                    end
                    default: begin
                        result = '0; // unknown funct.
                    end
                endcase
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rtl/RegisterFile.sv ====
`timescale 1ns/1ps

module RegisterFile (
    input  logic              clk,
    input  logic              rst,
    input  mipsPkg::regAddr_t readAddrA,
    input  mipsPkg::regAddr_t readAddrB,
    output mipsPkg::word_t    readDataA,
    output mipsPkg::word_t    readDataB,
    input  logic              writeEnable,
    input  mipsPkg::regAddr_t writeAddr,
    input  mipsPkg::word_t    writeData
);

    import mipsPkg::*;

    word_t regs [32];

    logic writeActive;

    // no writes land while the core is held in reset.
    assign writeActive = writeEnable && !rst && (writeAddr != '0);

    always_ff @(posedge clk) begin
        if (writeActive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // r0 reads as zero whatever was stored.
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== rtl/ProgramCounter.sv ====
`timescale 1ns/1ps

module ProgramCounter #(
    parameter mipsPkg::word_t resetVector = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           takeBranch,
    input  logic           jump,
    input  mipsPkg::word_t immediate,
    input  logic [25:0]    jumpTarget,
    output mipsPkg::word_t pc
);

    import mipsPkg::*;

    word_t pcPlus4;
    word_t branchAddr;
    word_t jumpAddr;
    word_t nextPc;

    assign pcPlus4    = pc + 32'd4;
    assign branchAddr = pcPlus4 + {immediate[29:0], 2'b00}; // word offset.
    assign jumpAddr   = {pcPlus4[31:28], jumpTarget, 2'b00};

    always_comb begin
        if (jump) begin
            nextPc = jumpAddr;
        end else if (takeBranch) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== rtl/MipsCore.sv ====
`timescale 1ns/1ps

module MipsCore #(
    parameter mipsPkg::word_t resetVector = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    output mipsPkg::word_t instrAddr,
    input  mipsPkg::word_t instr,
    output mipsPkg::word_t dataAddr,
    output mipsPkg::word_t dataWdata,
    output logic           dataWe,
    output logic           dataRe,
    input  mipsPkg::word_t dataRdata
);

    import mipsPkg::*;

    // instruction fields.
    opCode_t     opCode;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    funct_t      funct;
    logic [25:0] jumpTarget;
    word_t       signExtImm;

    // decoder outputs.
    logic   regDst;
    logic   jump;
    logic   branch;
    logic   memRead;
    logic   memToReg;
    logic   memWrite;
    logic   aluSource;
    logic   regWrite;
    aluOp_t aluOp;

    regAddr_t writeAddr;
    word_t    writeBack;
    word_t    readDataA;
    word_t    readDataB;
    word_t    aluB;
    word_t    aluResult;
    logic     aluZero;
    logic     takeBranch;

    assign opCode     = instr[31:26];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign funct      = instr[5:0];
    assign jumpTarget = instr[25:0];
    assign signExtImm = {{16{instr[15]}}, instr[15:0]};

    ControlUnit ControlUnit_inst (
        .opCode    (opCode),
        .regDst    (regDst),
        .jump      (jump),
        .branch    (branch),
        .memRead   (memRead),
        .memToReg  (memToReg),
        .aluOp     (aluOp),
        .memWrite  (memWrite),
        .aluSource (aluSource),
        .regWrite  (regWrite)
    );

    assign writeAddr = regDst ? rd : rt;
    assign writeBack = memToReg ? dataRdata : aluResult; // load or ALU result.

    RegisterFile RegisterFile_inst (
        .clk         (clk),
        .rst         (rst),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (regWrite),
        .writeAddr   (writeAddr),
        .writeData   (writeBack)
    );

    assign aluB = aluSource ? signExtImm : readDataB;

    Alu Alu_inst (
        .a      (readDataA),
        .b      (aluB),
        .aluOp  (aluOp),
        .funct  (funct),
        .result (aluResult),
        .zero   (aluZero)
    );

    // beq taken only on equal operands.
    assign takeBranch = branch & aluZero;

    ProgramCounter #(
        .resetVector (resetVector)
    ) ProgramCounter_inst (
        .clk        (clk),
        .rst        (rst),
        .takeBranch (takeBranch),
        .jump       (jump),
        .immediate  (signExtImm),
        .jumpTarget (jumpTarget),
        .pc         (instrAddr)
    );

    assign dataAddr  = aluResult;
    assign dataWdata = readDataB;
    // memory strobes stay quiet through reset.
    assign dataWe    = memWrite & ~rst;
    assign dataRe    = memRead & ~rst;

endmodule

// ==== bench/MipsCore_assertions.sv ====
`timescale 1ns/1ps

module MipsCoreAssertions #(
    parameter mipsPkg::word_t resetVector = 32'h0000_0000
) (
    input logic           clk,
    input logic           rst,
    input mipsPkg::word_t instrAddr,
    input logic           dataWe,
    input logic           dataRe
);

    // a cycle loads or stores, never both.
    strobeExclusive: assert property (@(posedge clk) !(dataWe && dataRe))
        else $error("dataWe and dataRe high in the same cycle");

    strobeQuietInReset: assert property (@(posedge clk) rst |-> (!dataWe && !dataRe))
        else $error("memory strobe high while rst is held");

    fetchAligned: assert property (@(posedge clk) disable iff (rst) instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

    // first fetch after reset.
    fetchStart: assert property (@(posedge clk) $fell(rst) |-> instrAddr == resetVector)
        else $error("first fetch after reset not at the reset vector");

endmodule

bind MipsCore MipsCoreAssertions #(
    .resetVector (resetVector)
) MipsCoreAssertions_inst (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .dataWe    (dataWe),
    .dataRe    (dataRe)
);

// ==== bench/MipsCoreTb.sv ====
`timescale 1ns/1ps

module MipsCoreTb;

    import mipsPkg::*;

    typedef struct packed {
        word_t instr;
        logic  hasStore;
        word_t addr;
        word_t value;
    } progRow_t;

    localparam word_t resetVector  = 32'h0000_0000;
    localparam int    StoreTimeout = 200;
    localparam int    QuietCycles  = 20;

    logic  clk;
    logic  rst;
    word_t instrAddr;
    word_t instr;
    word_t dataAddr;
    word_t dataWdata;
    logic  dataWe;
    logic  dataRe;
    word_t dataRdata;

    word_t    imem [64];
    word_t    dmem [16];
    word_t    fetchOffset;
    progRow_t prog [$];
    word_t    expAddr [$];
    word_t    expData [$];
    word_t    lfsrState;
    word_t    wantAddr;
    word_t    wantData;
    logic     wantRead;
    word_t    loopAddr;
    int       valueErrors;
    int       otherErrors;
    int       storeCount;

    MipsCore #(
        .resetVector (resetVector)
    ) MipsCore_inst (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .dataRe    (dataRe),
        .dataRdata (dataRdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign fetchOffset = instrAddr - resetVector; // imem starts at the reset vector.
    assign instr       = imem[fetchOffset[7:2]];
    assign dataRdata   = dmem[dataAddr[5:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[5:2]] <= dataWdata;
        end
    end

    function automatic word_t lfsrStep(input word_t s);
        word_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one LFSR step per bit.
    task automatic nextRandomWord(output word_t w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            w         = {w[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic word_t encodeR(input regAddr_t rs, input regAddr_t rt,
                                      input regAddr_t rd, input funct_t fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(input opCode_t op, input regAddr_t rs,
                                      input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeJ(input int idx);
        word_t dest;
        dest = resetVector + word_t'(idx * 4);
        return {opJ, dest[27:2]};
    endfunction

    task automatic addOp(input word_t ins);
        prog.push_back({ins, 1'b0, 32'd0, 32'd0});
    endtask

    task automatic addStore(input word_t ins, input word_t addr, input word_t value);
        prog.push_back({ins, 1'b1, addr, value});
    endtask

    task automatic seedDataMemory();
        int i;
        lfsrState = 32'h77de;
        for (i = 0; i < 16; i++) begin
            nextRandomWord(dmem[i]);
        end
    endtask

    task automatic buildProgram();
        word_t a;
        word_t b;
        a = dmem[0];
        b = dmem[1];
        addOp(encodeI(opLw, 5'd0, 5'd1, 16'h0000));
        addOp(encodeI(opLw, 5'd0, 5'd2, 16'h0004));
        addOp(encodeR(5'd1, 5'd2, 5'd3, fnAdd));
        addStore(encodeI(opSw, 5'd0, 5'd3, 16'h0020), 32'h20, a + b);
        addOp(encodeR(5'd1, 5'd2, 5'd4, fnSub));
        addStore(encodeI(opSw, 5'd0, 5'd4, 16'h0024), 32'h24, a - b);
        addOp(encodeR(5'd1, 5'd2, 5'd5, fnAnd));
        addStore(encodeI(opSw, 5'd0, 5'd5, 16'h0028), 32'h28, a & b);
        addOp(encodeR(5'd1, 5'd2, 5'd6, fnOr));
        addStore(encodeI(opSw, 5'd0, 5'd6, 16'h002C), 32'h2C, a | b);
        addOp(encodeR(5'd1, 5'd2, 5'd7, fnSlt));
        addStore(encodeI(opSw, 5'd0, 5'd7, 16'h0030), 32'h30,
                 ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        addOp(encodeI(opAddi, 5'd0, 5'd10, 16'hFFFF));
        addOp(encodeR(5'd10, 5'd0, 5'd11, fnSlt)); // -1 < 0 only when signed.
        addStore(encodeI(opSw, 5'd0, 5'd11, 16'h0008), 32'h08, 32'd1);
        addOp(encodeI(opAddi, 5'd1, 5'd8, 16'hFED4));
        addStore(encodeI(opSw, 5'd0, 5'd8, 16'h0034), 32'h34, a + 32'hFFFF_FED4);
        addOp(encodeI(opBeq, 5'd1, 5'd1, 16'h0001)); // taken.
        addOp(encodeI(opSw, 5'd0, 5'd1, 16'h0038));
        addOp(encodeI(opAddi, 5'd0, 5'd9, 16'h0005));
        addOp(encodeI(opBeq, 5'd9, 5'd0, 16'h0001)); // falls through.
        addStore(encodeI(opSw, 5'd0, 5'd9, 16'h0038), 32'h38, 32'd5);
        addOp(encodeJ(prog.size() + 2));
        addOp(encodeI(opSw, 5'd0, 5'd2, 16'h003C)); // jumped over.
        addOp(encodeI(opAddi, 5'd0, 5'd0, 16'h0007));
        addStore(encodeI(opSw, 5'd0, 5'd0, 16'h003C), 32'h3C, 32'd0);
        // park the core here.
        loopAddr = resetVector + word_t'(prog.size() * 4);
        addOp(encodeJ(prog.size()));
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < 64; i++) begin
            imem[i] = encodeJ(i); // every spare word jumps to itself.
        end
        for (i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i].instr;
            if (prog[i].hasStore) begin
                expAddr.push_back(prog[i].addr);
                expData.push_back(prog[i].value);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            assert (!dataWe && !dataRe) else begin
                otherErrors++;
                $display("memory strobe raised while reset is held");
            end
        end else begin
            wantRead = (instr[31:26] == opLw); // only lw reads data memory.
            assert (dataRe == wantRead) else begin
                valueErrors++;
                $display("Error dataRe: expected %h, got %h", wantRead, dataRe);
            end
            if (dataWe) begin
                storeCount++;
                assert (expAddr.size() != 0) else begin
                    otherErrors++;
                    $display("store to %h appeared where the program has none", dataAddr);
                end
                if (expAddr.size() != 0) begin
                    wantAddr = expAddr.pop_front();
                    wantData = expData.pop_front();
                    assert (dataAddr == wantAddr) else begin
                        valueErrors++;
                        $display("Error dataAddr: expected %h, got %h", wantAddr, dataAddr);
                    end
                    assert (dataWdata == wantData) else begin
                        valueErrors++;
                        $display("Error dataWdata: expected %h, got %h",
                                 wantData, dataWdata);
                    end
                end
            end
        end
    end

    task automatic waitForStores();
        int n;
        n = 0;
        while (expAddr.size() != 0 && n < StoreTimeout) begin
            @(negedge clk);
            n++;
        end
        assert (expAddr.size() == 0) else begin
            otherErrors++;
            $display("timed out with %0d expected stores never seen on the data port",
                     expAddr.size());
        end
    endtask

    // the self-loop must hold the PC still.
    task automatic holdAtLoop();
        int n;
        n = 0;
        while (n < QuietCycles) begin
            @(negedge clk);
            assert (instrAddr == loopAddr) else begin
                valueErrors++;
                $display("Error instrAddr: expected %h, got %h", loopAddr, instrAddr);
            end
            n++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        valueErrors = 0;
        otherErrors = 0;
        storeCount  = 0;
        seedDataMemory();
        buildProgram();
        loadProgram();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        #1;
        assert (instrAddr == resetVector) else begin
            valueErrors++;
            $display("Error instrAddr: expected %h, got %h", resetVector, instrAddr);
        end
        waitForStores();
        holdAtLoop();
        $display("Summary: %0d value errors, %0d other errors, %0d stores seen",
                 valueErrors, otherErrors, storeCount);
        if (valueErrors + otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
rtl/mipsPkg.sv
rtl/ControlUnit.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/ProgramCounter.sv
rtl/MipsCore.sv
bench/MipsCore_assertions.sv
bench/MipsCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = MipsCoreTb
FILELIST  = project.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a listed source or the list itself changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
